// ==== bench/bp_tb_tasks.svh ====
////////////////////////////////////////////////////////////
// Checks and driving
////////////////////////////////////////////////////////////

task automatic stop_with_failure();
   $display("Errors found");
   $fatal(1, "Stopped at the first mismatch");
endtask

task automatic check_pred(pred_s act, pred_s exp, string what);
   if (act !== exp) begin
      $display("ERROR at time %0t: %s expected taken %b ckpt %h, got taken %b ckpt %h",
               $time, what, exp.taken, exp.ckpt, act.taken, act.ckpt);
      stop_with_failure();
   end
endtask

task automatic check_ghist(ghist_t act, ghist_t exp, string what);
   if (act !== exp) begin
      $display("ERROR at time %0t: %s expected %h got %h", $time, what, exp, act);
      stop_with_failure();
   end
endtask

task automatic check_bit(logic act, logic exp, string what);
   if (act !== exp) begin
      $display("ERROR at time %0t: %s expected %b got %b", $time, what, exp, act);
      stop_with_failure();
   end
endtask

function automatic fetch_s make_fetch(logic [31:0] pc0, logic [31:0] pc1, logic [1:0] br);
   fetch_s f;
   f.valid     = 1'b1;
   f.pc[0]     = pc0;
   f.pc[1]     = pc1;
   f.is_branch = br;
   return f;
endfunction

function automatic update_s make_update(logic [31:0] pc, logic taken, ckpt_s ck);
   update_s u;
   u.valid = 1'b1;
   u.pc    = pc;
   u.taken = taken;
   u.ckpt  = ck;
   return u;
endfunction

// Drive on the falling edge, compare mid-cycle, then step the model
task automatic run_cycle(input fetch_s f, input update_s u, output pred_grp_t seen);
   pred_grp_t expd;
   @(negedge clk);
   fetch_drv = f;
   upd_drv   = u;
   #(PERIOD / 4);
   expd = model_predict(f);
   seen = pred_obs;
   check_ghist(seen[0].ckpt.ghist, ghist_m, "global history");
   for (int s = 0; s < SLOTS; s++)
      check_pred(seen[s], expd[s], $sformatf("slot %0d prediction", s));
   model_advance(f, u, expd);
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic init_sweep_and_ready();
   pred_grp_t p;
   check_bit(ready_obs, 1'b0, "ready_o at reset release");
   // Ready first shows in cycle ENTRIES+1
   for (int c = 1; c <= ENTRIES; c++) begin
      @(negedge clk);
      check_bit(ready_obs, c == ENTRIES, $sformatf("ready_o %0d cycles after release", c));
   end
   for (int i = 0; i < ENTRIES; i++) begin
      bim_m[i] = WEAK_NT;
      gsh_m[i] = WEAK_NT;
      sel_m[i] = STRONG_BIMODAL;
   end
   ready_m = 1'b1;
   for (int k = 0; k < 4; k++) begin
      run_cycle(make_fetch(32'h2000 + 8 * k, 32'h2004 + 8 * k, 2'b11), NO_UPDATE, p);
      check_bit(p[0].taken | p[1].taken, 1'b0, "untrained prediction");
      check_bit(p[0].ckpt.use_gshare | p[1].ckpt.use_gshare, 1'b0, "chooser after init");
      check_ghist(p[1].ckpt.ghist, '0, "slot 1 history after init");
   end
endtask

task automatic bimodal_training();
   pred_grp_t p;
   pred_grp_t q;
   run_cycle(make_fetch(32'h100, 32'h104, 2'b01), NO_UPDATE, p);
   check_bit(p[0].taken, 1'b0, "bimodal before training");
   run_cycle(NO_FETCH, make_update(32'h100, 1'b1, p[0].ckpt), q);
   run_cycle(make_fetch(32'h100, 32'h100, 2'b01), NO_UPDATE, p);
   check_bit(p[0].taken, 1'b1, "bimodal after taken update");
   check_bit(p[1].taken, 1'b0, "non-branch slot at trained pc");
   run_cycle(NO_FETCH, make_update(32'h100, 1'b0, p[0].ckpt), q);
   run_cycle(make_fetch(32'h100, 32'h100, 2'b01), NO_UPDATE, p);
   check_bit(p[0].taken, 1'b0, "bimodal after not-taken update");
endtask

task automatic speculative_history();
   pred_grp_t p;
   pred_grp_t q;
   ghist_t    h0;
   run_cycle(make_fetch(32'h204, 32'h208, 2'b11), NO_UPDATE, p);
   repeat (2) run_cycle(NO_FETCH, make_update(32'h204, 1'b1, p[0].ckpt), q);
   h0 = ghist_m;
   run_cycle(make_fetch(32'h204, 32'h208, 2'b11), NO_UPDATE, p);
   check_bit(p[0].taken, 1'b1, "trained slot 0");
   check_ghist(p[1].ckpt.ghist, push_hist(h0, 1'b1), "slot 1 history");
   run_cycle(NO_FETCH, NO_UPDATE, q);
   // Slot 1 pc was never trained and guesses not taken
   check_ghist(q[0].ckpt.ghist, push_hist(push_hist(h0, 1'b1), 1'b0),
               "history after two branches");
endtask

task automatic chooser_switching();
   pred_grp_t p;
   pred_grp_t q;
   ckpt_s     ck;
   // Two updates where gshare was right and bimodal wrong
   // All-ones history repairs to itself
   ck = '{ghist: HMASK, bim_taken: 1'b0, gsh_taken: 1'b1, use_gshare: 1'b0};
   repeat (2) run_cycle(NO_FETCH, make_update(32'h330, 1'b1, ck), q);
   run_cycle(make_fetch(32'h330, 32'h334, 2'b01), NO_UPDATE, p);
   check_bit(p[0].ckpt.use_gshare, 1'b1, "chooser after two gshare wins");
   check_bit(p[0].taken, 1'b1, "gshare entry at trained history");
   ck = '{ghist: '0, bim_taken: 1'b1, gsh_taken: 1'b1, use_gshare: 1'b0};
   run_cycle(NO_FETCH, make_update(32'h340, 1'b0, ck), q);   // Forces history to zero
   run_cycle(make_fetch(32'h330, 32'h334, 2'b01), NO_UPDATE, p);
   check_bit(p[0].ckpt.bim_taken, 1'b1, "bimodal at chooser pc");
   check_bit(p[0].taken, 1'b0, "untrained gshare entry overrides bimodal");
endtask

task automatic mispredict_recovery();
   pred_grp_t p;
   pred_grp_t q;
   ghist_t    h0;
   h0 = ghist_m;
   run_cycle(make_fetch(32'h204, 32'h208, 2'b01), NO_UPDATE, p);
   check_bit(p[0].taken, 1'b1, "slot 0 before recovery");
   run_cycle(make_fetch(32'h204, 32'h208, 2'b11), make_update(32'h204, 1'b0, p[0].ckpt),
             q);
   run_cycle(NO_FETCH, NO_UPDATE, q);
   check_ghist(q[0].ckpt.ghist, push_hist(h0, 1'b0), "history after recovery");
endtask

// ==== bench/bp_tb.sv ====
module bp_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import bp_pkg::*;

   localparam int      ENTRIES   = 32;
   localparam int      IW        = $clog2(ENTRIES);
   localparam int      PERIOD    = 40;
   localparam ghist_t  HMASK     = ghist_t'((1 << IW) - 1);   // Kept history bits
   localparam fetch_s  NO_FETCH  = '0;
   localparam update_s NO_UPDATE = '0;

   typedef pred_s [SLOTS-1:0] pred_grp_t;

   logic      clk;
   logic      reset;
   fetch_s    fetch_drv;
   update_s   upd_drv;
   pred_grp_t pred_obs;
   logic      ready_obs;
   integer    seed;

   // Reference model of the three tables and the history
   logic [1:0] bim_m [ENTRIES];
   logic [1:0] gsh_m [ENTRIES];
   logic [1:0] sel_m [ENTRIES];
   ghist_t     ghist_m;
   logic       ready_m;

   bp_top #(.ENTRIES(ENTRIES)) dut (
      .clk,
      .reset,
      .fetch_i  (fetch_drv),
      .update_i (upd_drv),
      .pred_o   (pred_obs),
      .ready_o  (ready_obs)
   );

   always #(PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Model rules
   ////////////////////////////////////////////////////////////

   function automatic logic [1:0] step_ctr(logic [1:0] v, logic up);
      if (up)
         return (v == 2'b11) ? v : v + 2'd1;   // Saturate at the top
      return (v == 2'b00) ? v : v - 2'd1;
   endfunction

   function automatic ghist_t push_hist(ghist_t h, logic b);
      return ((h << 1) | ghist_t'(b)) & HMASK;
   endfunction

   function automatic pred_grp_t model_predict(fetch_s f);
      pred_grp_t     p;
      ghist_t        h;
      logic [IW-1:0] pi;
      logic [IW-1:0] gi;
      h = ghist_m;
      for (int s = 0; s < SLOTS; s++) begin
         pi = f.pc[s][IW+1:2];
         gi = pi ^ h[IW-1:0];
         p[s].ckpt.ghist      = h;
         p[s].ckpt.bim_taken  = bim_m[pi][1];
         p[s].ckpt.gsh_taken  = gsh_m[gi][1];
         p[s].ckpt.use_gshare = sel_m[pi][1];
         p[s].taken = ready_m && f.is_branch[s] && (sel_m[pi][1] ? gsh_m[gi][1] : bim_m[pi][1]);
         if (f.valid && f.is_branch[s])
            h = push_hist(h, p[s].taken);        // Later slot sees the earlier guess
      end
      return p;
   endfunction

   function automatic void model_advance(fetch_s f, update_s u, pred_grp_t p);
      logic [IW-1:0] pi;
      logic [IW-1:0] gi;
      logic          chosen;
      pi     = u.pc[IW+1:2];
      gi     = pi ^ u.ckpt.ghist[IW-1:0];
      chosen = u.ckpt.use_gshare ? u.ckpt.gsh_taken : u.ckpt.bim_taken;
      if (ready_m && u.valid) begin
         bim_m[pi] = step_ctr(bim_m[pi], u.taken);
         gsh_m[gi] = step_ctr(gsh_m[gi], u.taken);
         if (u.ckpt.bim_taken != u.ckpt.gsh_taken)
            sel_m[pi] = step_ctr(sel_m[pi], u.ckpt.gsh_taken == u.taken);
      end
      if (ready_m && u.valid && u.taken != chosen) begin
         ghist_m = push_hist(u.ckpt.ghist, u.taken);   // Repair beats the fetch
      end else if (ready_m && f.valid) begin
         for (int s = 0; s < SLOTS; s++)
            if (f.is_branch[s])
               ghist_m = push_hist(ghist_m, p[s].taken);
      end
   endfunction

   `include "bp_tb_tasks.svh"

   task automatic random_traffic();
      ckpt_s       ck_q [$];
      logic [31:0] pc_q [$];
      logic [31:0] r_pc;
      logic [31:0] r_ctl;
      fetch_s      f;
      update_s     u;
      pred_grp_t   p;
      for (int n = 0; n < 300; n++) begin
         r_pc  = $random(seed);
         r_ctl = $random(seed);
         f = make_fetch(32'h1000 | (r_pc & 32'h7c), (32'h1000 | (r_pc & 32'h7c)) + 32'd4,
                        r_ctl[1:0]);
         f.valid = r_ctl[3:2] != 2'b00;
         u = NO_UPDATE;
         if (ck_q.size() > 0 && (r_ctl[4] || ck_q.size() > 6)) begin
            u = make_update(pc_q.pop_front(), r_ctl[6:5] != 2'b00, ck_q.pop_front());
         end
         run_cycle(f, u, p);
         for (int s = 0; s < SLOTS; s++) begin
            if (f.valid && f.is_branch[s]) begin
               pc_q.push_back(f.pc[s]);
               ck_q.push_back(p[s].ckpt);         // Resolved later in fetch order
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      clk       = 1'b0;
      reset     = 1'b0;
      fetch_drv = NO_FETCH;
      upd_drv   = NO_UPDATE;
      ghist_m   = '0;
      ready_m   = 1'b0;
      seed      = 32'ha600;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;
      init_sweep_and_ready();
      bimodal_training();
      speculative_history();
      chooser_switching();
      mispredict_recovery();
      random_traffic();
      $display("No errors");
      $finish;
   end

endmodule

// ==== rtl/bp_pkg.sv ====
package bp_pkg;

   ////////////////////////////////////////////////////////////
   // Fetch group and history sizes
   ////////////////////////////////////////////////////////////

   localparam int SLOTS    = 2;   // Instructions per fetch group
   localparam int HIST_MAX = 16;  // Widest history a table can hash with

   typedef logic [HIST_MAX-1:0] ghist_t;

   ////////////////////////////////////////////////////////////
   // Counter encodings
   ////////////////////////////////////////////////////////////

   // Upper bit is the taken prediction
   typedef enum logic [1:0] {
      STRONG_NT = 2'b00,
      WEAK_NT   = 2'b01,
      WEAK_T    = 2'b10,
      STRONG_T  = 2'b11
   } dir_ctr_e;

   // Upper bit selects the gshare component
   typedef enum logic [1:0] {
      STRONG_BIMODAL = 2'b00,
      WEAK_BIMODAL   = 2'b01,
      WEAK_GSHARE    = 2'b10,
      STRONG_GSHARE  = 2'b11
   } sel_ctr_e;

   ////////////////////////////////////////////////////////////
   // Fetch, prediction and update bundles
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                    valid;
      logic [SLOTS-1:0][31:0]  pc;
      logic [SLOTS-1:0]        is_branch;
   } fetch_s;

   // Everything training needs to know about one prediction
   typedef struct packed {
      ghist_t ghist;       // History this slot hashed with
      logic   bim_taken;
      logic   gsh_taken;
      logic   use_gshare;
   } ckpt_s;

   typedef struct packed {
      logic  taken;
      ckpt_s ckpt;
   } pred_s;

   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic        taken;        // Resolved outcome
      ckpt_s       ckpt;
   } update_s;

endpackage

// ==== rtl/bp_top.sv ====
module bp_top #(
      parameter int ENTRIES = 32
   )(
      input  logic                              clk,
      input  logic                              reset,
      input  bp_pkg::fetch_s                    fetch_i,
      input  bp_pkg::update_s                   update_i,
      output bp_pkg::pred_s [bp_pkg::SLOTS-1:0] pred_o,
      output logic                              ready_o
   );

   import bp_pkg::*;

   localparam int IW = $clog2(ENTRIES);

   logic                      init_en;
   logic [IW-1:0]             init_idx;
   logic                      ready;
   ghist_t                    ghist_q;
   logic [1:0]                shift_cnt;
   logic [1:0]                shift_bits;
   logic                      recover;
   ghist_t                    restore;
   logic [SLOTS-1:0][IW-1:0]  pc_idx;
   logic [SLOTS-1:0][IW-1:0]  gsh_idx;
   dir_ctr_e                  bim_ctr [SLOTS];
   dir_ctr_e                  gsh_ctr [SLOTS];
   sel_ctr_e                  sel_ctr [SLOTS];
   logic                      dir_wr_en;
   logic                      dir_wr_up;
   logic [IW-1:0]             pc_wr_idx;
   logic [IW-1:0]             gsh_wr_idx;
   logic                      sel_wr_en;
   logic                      sel_wr_up;

   table_init_fsm #(.ENTRIES(ENTRIES)) init_fsm (
      .clk, .reset,
      .init_en_o  (init_en),
      .init_idx_o (init_idx),
      .ready_o    (ready)
   );

   global_history #(.HIST_W(IW)) ghist (
      .clk, .reset,
      .shift_cnt_i  (shift_cnt),
      .shift_bits_i (shift_bits),
      .recover_i    (recover),
      .restore_i    (restore),
      .ghist_o      (ghist_q)
   );

   tournament_predictor #(.ENTRIES(ENTRIES)) predictor (
      .clk, .reset,
      .ready_i (ready), .ghist_i (ghist_q),
      .fetch_i, .update_i, .pred_o,
      .shift_cnt_o (shift_cnt), .shift_bits_o (shift_bits),
      .recover_o (recover), .restore_o (restore),
      .pc_idx_o (pc_idx), .gsh_idx_o (gsh_idx),
      .bim_ctr_i (bim_ctr), .gsh_ctr_i (gsh_ctr), .sel_ctr_i (sel_ctr),
      .dir_wr_en_o (dir_wr_en), .dir_wr_up_o (dir_wr_up),
      .pc_wr_idx_o (pc_wr_idx), .gsh_wr_idx_o (gsh_wr_idx),
      .sel_wr_en_o (sel_wr_en), .sel_wr_up_o (sel_wr_up)
   );

   ////////////////////////////////////////////////////////////
   // Counter tables
   ////////////////////////////////////////////////////////////

   sat_counter_table #(.ENTRIES(ENTRIES), .CTR_T(dir_ctr_e), .INIT_VAL(WEAK_NT)) bim_tbl (
      .clk, .reset,
      .rd_idx_i (pc_idx), .rd_ctr_o (bim_ctr),
      .wr_en_i (dir_wr_en), .wr_idx_i (pc_wr_idx), .wr_up_i (dir_wr_up),
      .init_en_i (init_en), .init_idx_i (init_idx)
   );

   sat_counter_table #(.ENTRIES(ENTRIES), .CTR_T(dir_ctr_e), .INIT_VAL(WEAK_NT)) gsh_tbl (
      .clk, .reset,
      .rd_idx_i (gsh_idx), .rd_ctr_o (gsh_ctr),
      .wr_en_i (dir_wr_en), .wr_idx_i (gsh_wr_idx), .wr_up_i (dir_wr_up),
      .init_en_i (init_en), .init_idx_i (init_idx)
   );

   // Chooser starts out trusting bimodal
   sat_counter_table #(.ENTRIES(ENTRIES), .CTR_T(sel_ctr_e), .INIT_VAL(STRONG_BIMODAL)) sel_tbl (
      .clk, .reset,
      .rd_idx_i (pc_idx), .rd_ctr_o (sel_ctr),
      .wr_en_i (sel_wr_en), .wr_idx_i (pc_wr_idx), .wr_up_i (sel_wr_up),
      .init_en_i (init_en), .init_idx_i (init_idx)
   );

   assign ready_o = ready;

endmodule

// ==== rtl/global_history.sv ====
module global_history #(
      parameter int HIST_W = 5    // Bits actually kept
   )(
      input  logic           clk,
      input  logic           reset,

      // Speculative shift, bit 0 goes in first
      input  logic [1:0]     shift_cnt_i,
      input  logic [1:0]     shift_bits_i,

      // Misprediction repair
      input  logic           recover_i,
      input  bp_pkg::ghist_t restore_i,

      output bp_pkg::ghist_t ghist_o
   );

   import bp_pkg::*;

   localparam ghist_t HIST_MASK = ghist_t'((64'd1 << HIST_W) - 1);

   ghist_t ghist_q;
   ghist_t ghist_d;

   always_comb begin
      ghist_d = ghist_q;
      if (recover_i) begin
         ghist_d = restore_i;               // Repair beats any shift
      end else begin
         case (shift_cnt_i)
            2'd1:    ghist_d = {ghist_q[HIST_MAX-2:0], shift_bits_i[0]};
            2'd2:    ghist_d = {ghist_q[HIST_MAX-3:0], shift_bits_i[0], shift_bits_i[1]};
            default: ghist_d = ghist_q;
         endcase
      end
      ghist_d = ghist_d & HIST_MASK;
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         ghist_q <= '0;
      end else begin
         ghist_q <= ghist_d;
      end
   end

   assign ghist_o = ghist_q;

   // Two slots per group, so never more than two new bits
   a_shift_range : assert property (
      @(posedge clk) disable iff (!reset)
      shift_cnt_i <= 2'd2
   ) else $error("history shift count above two");

endmodule

// ==== rtl/sat_counter_table.sv ====
module sat_counter_table #(
      parameter int  ENTRIES  = 32,
      parameter type CTR_T    = logic [1:0],
      parameter CTR_T INIT_VAL = CTR_T'(0)
   )(
      input  logic                                        clk,
      input  logic                                        reset,

      // Prediction side, one port per fetch slot
      input  logic [bp_pkg::SLOTS-1:0][$clog2(ENTRIES)-1:0] rd_idx_i,
      output CTR_T                                        rd_ctr_o [bp_pkg::SLOTS],

      // Training side
      input  logic                                        wr_en_i,
      input  logic [$clog2(ENTRIES)-1:0]                  wr_idx_i,
      input  logic                                        wr_up_i,    // Step up when set

      // Sweep after reset
      input  logic                                        init_en_i,
      input  logic [$clog2(ENTRIES)-1:0]                  init_idx_i
   );

   import bp_pkg::*;

   localparam int CW = $bits(CTR_T);

   CTR_T          ctr_mem [ENTRIES];
   logic [CW-1:0] cur_val;
   logic [CW-1:0] nxt_val;

   ////////////////////////////////////////////////////////////
   // Combinational reads
   ////////////////////////////////////////////////////////////

   for (genvar s = 0; s < SLOTS; s++) begin : g_rd
      assign rd_ctr_o[s] = ctr_mem[rd_idx_i[s]];
   end

   ////////////////////////////////////////////////////////////
   // Saturating read-modify-write
   ////////////////////////////////////////////////////////////

   always_comb begin
      cur_val = ctr_mem[wr_idx_i];
      nxt_val = cur_val;
      if (wr_up_i) begin
         if (cur_val != {CW{1'b1}})
            nxt_val = cur_val + 1'b1;       // Stop at the strong top state
      end else begin
         if (cur_val != {CW{1'b0}})
            nxt_val = cur_val - 1'b1;       // Stop at the strong bottom state
      end
   end

   // Contents come from the init sweep
   always_ff @(posedge clk) begin
      if (init_en_i) begin
         ctr_mem[init_idx_i] <= INIT_VAL;
      end else if (wr_en_i) begin
         ctr_mem[wr_idx_i] <= CTR_T'(nxt_val);
      end
   end

   // Training only starts once the sweep has finished
   a_no_train_during_init : assert property (
      @(posedge clk) disable iff (!reset)
      !(wr_en_i && init_en_i)
   ) else $error("table write during init sweep");

endmodule

// ==== rtl/table_init_fsm.sv ====
module table_init_fsm #(
      parameter int ENTRIES = 32
   )(
      input  logic                       clk,
      input  logic                       reset,
      output logic                       init_en_o,
      output logic [$clog2(ENTRIES)-1:0] init_idx_o,
      output logic                       ready_o
   );

   localparam int IW = $clog2(ENTRIES);

   typedef enum logic {
      SWEEP,
      READY
   } state_e;

   state_e        state_q;
   logic [IW-1:0] idx_q;       // Entry written this cycle

   ////////////////////////////////////////////////////////////
   // Sweep every table entry once, then stay ready
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state_q <= SWEEP;
         idx_q   <= '0;
      end else begin
         case (state_q)
            SWEEP: begin
               if (idx_q == IW'(ENTRIES - 1)) begin
                  state_q <= READY;          // Last entry goes out this edge
               end else begin
                  idx_q <= idx_q + 1'b1;
               end
            end
            default: state_q <= READY;      // Held until the next reset
         endcase
      end
   end

   assign init_en_o  = (state_q == SWEEP);
   assign init_idx_o = idx_q;
   assign ready_o    = (state_q == READY);

   // Matters when ENTRIES is not a power of two
   a_idx_in_range : assert property (
      @(posedge clk) disable iff (!reset)
      init_en_o |-> (init_idx_o < ENTRIES)
   ) else $error("init index past table end");

endmodule

// ==== rtl/tournament_predictor.sv ====
module tournament_predictor #(
      parameter int ENTRIES = 32
   )(
      input  logic                                          clk,
      input  logic                                          reset,
      input  logic                                          ready_i,
      input  bp_pkg::ghist_t                                ghist_i,

      input  bp_pkg::fetch_s                                fetch_i,
      input  bp_pkg::update_s                               update_i,
      output bp_pkg::pred_s [bp_pkg::SLOTS-1:0]             pred_o,

      // History control
      output logic [1:0]                                    shift_cnt_o,
      output logic [1:0]                                    shift_bits_o,
      output logic                                          recover_o,
      output bp_pkg::ghist_t                                restore_o,

      // Table reads, bimodal and chooser share the pc index
      output logic [bp_pkg::SLOTS-1:0][$clog2(ENTRIES)-1:0] pc_idx_o,
      output logic [bp_pkg::SLOTS-1:0][$clog2(ENTRIES)-1:0] gsh_idx_o,
      input  bp_pkg::dir_ctr_e                              bim_ctr_i [bp_pkg::SLOTS],
      input  bp_pkg::dir_ctr_e                              gsh_ctr_i [bp_pkg::SLOTS],
      input  bp_pkg::sel_ctr_e                              sel_ctr_i [bp_pkg::SLOTS],

      // Table writes
      output logic                                          dir_wr_en_o,
      output logic                                          dir_wr_up_o,
      output logic [$clog2(ENTRIES)-1:0]                    pc_wr_idx_o,
      output logic [$clog2(ENTRIES)-1:0]                    gsh_wr_idx_o,
      output logic                                          sel_wr_en_o,
      output logic                                          sel_wr_up_o
   );

   import bp_pkg::*;

   localparam int     IW        = $clog2(ENTRIES);
   localparam ghist_t HIST_MASK = ghist_t'((64'd1 << IW) - 1);

   ghist_t           slot_hist [SLOTS];   // History each slot hashes with
   logic [SLOTS-1:0] slot_br;             // Valid branch in this slot
   logic [SLOTS-1:0] slot_taken;
   logic             upd_en;
   logic             upd_chosen;

   ////////////////////////////////////////////////////////////
   // Per-slot hashing and selection
   ////////////////////////////////////////////////////////////

   for (genvar s = 0; s < SLOTS; s++) begin : g_slot
      logic bim_t;
      logic gsh_t;
      logic use_gsh;

      if (s == 0) begin : g_head
         assign slot_hist[s] = ghist_i;
      end else begin : g_chain
         // Earlier branch in the group already moved the history
         assign slot_hist[s] = slot_br[s-1] ?
                               ({slot_hist[s-1][HIST_MAX-2:0], slot_taken[s-1]} & HIST_MASK) :
                               slot_hist[s-1];
      end

      assign slot_br[s]   = fetch_i.valid & fetch_i.is_branch[s];
      assign pc_idx_o[s]  = fetch_i.pc[s][IW+1:2];
      assign gsh_idx_o[s] = fetch_i.pc[s][IW+1:2] ^ slot_hist[s][IW-1:0];

      assign bim_t   = bim_ctr_i[s] inside {WEAK_T, STRONG_T};
      assign gsh_t   = gsh_ctr_i[s] inside {WEAK_T, STRONG_T};
      assign use_gsh = sel_ctr_i[s] inside {WEAK_GSHARE, STRONG_GSHARE};

      assign slot_taken[s] = ready_i & fetch_i.is_branch[s] & (use_gsh ? gsh_t : bim_t);

      assign pred_o[s] = '{taken: slot_taken[s],
                           ckpt:  '{ghist:      slot_hist[s],
                                    bim_taken:  bim_t,
                                    gsh_taken:  gsh_t,
                                    use_gshare: use_gsh}};
   end

   ////////////////////////////////////////////////////////////
   // Training
   ////////////////////////////////////////////////////////////

   assign upd_en     = update_i.valid & ready_i;
   assign upd_chosen = update_i.ckpt.use_gshare ? update_i.ckpt.gsh_taken :
                                                  update_i.ckpt.bim_taken;

   assign dir_wr_en_o  = upd_en;              // Both direction tables follow the outcome
   assign dir_wr_up_o  = update_i.taken;
   assign pc_wr_idx_o  = update_i.pc[IW+1:2];
   assign gsh_wr_idx_o = update_i.pc[IW+1:2] ^ update_i.ckpt.ghist[IW-1:0];

   // Chooser only learns when the components disagreed
   assign sel_wr_en_o = upd_en & (update_i.ckpt.bim_taken != update_i.ckpt.gsh_taken);
   assign sel_wr_up_o = (update_i.ckpt.gsh_taken == update_i.taken);

   ////////////////////////////////////////////////////////////
   // History control
   ////////////////////////////////////////////////////////////

   assign recover_o = upd_en & (update_i.taken != upd_chosen);
   assign restore_o = {update_i.ckpt.ghist[HIST_MAX-2:0], update_i.taken};

   always_comb begin
      shift_cnt_o  = 2'd0;
      shift_bits_o = slot_br[0] ? {slot_taken[1], slot_taken[0]} : {1'b0, slot_taken[1]};
      if (fetch_i.valid && ready_i && !recover_o)
         shift_cnt_o = 2'(slot_br[0]) + 2'(slot_br[1]);   // Packed toward bit 0
   end

   // History register must still be clear until tables are live
   a_quiet_until_ready : assert property (
      @(posedge clk) disable iff (!reset)
      !ready_i |-> (!recover_o && (ghist_i == '0))
   ) else $error("history activity before ready");

endmodule

// ==== sources.f ====
+incdir+bench
rtl/bp_pkg.sv
rtl/sat_counter_table.sv
rtl/global_history.sv
rtl/table_init_fsm.sv
rtl/tournament_predictor.sv
rtl/bp_top.sv
bench/bp_tb.sv
